// File: source/alu_pkg.sv
////////////////////////////////////////
// ALU and register file shared types
// Word, index, opcode and flag definitions
////////////////////////////////////////
package alu_pkg;

  ////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////
  typedef logic [31:0] word_t;       // Register contents, ALU operands
  typedef logic [4:0]  reg_index_t;  // Register number, 32 max
  typedef logic [3:0]  alu_op_t;     // ALU control code
  typedef logic [2:0]  alu_flags_t;  // {carry, zero, overflow}

  ////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////
  // MIPS ALU control encoding
  localparam alu_op_t OP_AND = 4'd0;
  localparam alu_op_t OP_OR  = 4'd1;
  localparam alu_op_t OP_ADD = 4'd2;
  localparam alu_op_t OP_SUB = 4'd6;
  localparam alu_op_t OP_SLT = 4'd7;
  localparam alu_op_t OP_NOR = 4'd12;

  // Bit positions inside alu_flags_t
  localparam int FLAG_CARRY = 2;  // MSB
  localparam int FLAG_ZERO  = 1;
  localparam int FLAG_OVF   = 0;  // LSB

endpackage

// File: source/alu_32.sv
////////////////////////////////////////
// 32-bit ALU
// and, or, add, sub, slt, nor plus flags
////////////////////////////////////////
`timescale 1ns/1ns

module alu_32
  import alu_pkg::*;
(
  input  word_t      a,
  input  word_t      b,
  input  alu_op_t    op,
  output word_t      result,
  output alu_flags_t flags
);

  logic [32:0] sum;      // a + b, bit 32 is carry out
  logic [32:0] diff;     // a + ~b + 1, bit 32 is carry out
  logic        add_ovf;  // Signed overflow of add
  logic        sub_ovf;  // Signed overflow of sub
  logic        known;    // Opcode recognized

  ////////////////////////////////////////
  // Adder paths
  ////////////////////////////////////////
  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} + {1'b0, ~b} + 33'd1;  // Two's complement subtract

  // Same operand signs, different result sign
  assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
  // Operand signs differ and result sign flips away from a
  assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////
  always_comb
  begin
    result = '0;
    flags  = '0;
    known  = 1'b1;
    case (op)
      OP_AND: result = a & b;
      OP_OR:  result = a | b;
      OP_ADD:
      begin
        result            = sum[31:0];
        flags[FLAG_CARRY] = sum[32];
        flags[FLAG_OVF]   = add_ovf;
      end
      OP_SUB:
      begin
        result            = diff[31:0];
        flags[FLAG_CARRY] = diff[32];  // Set when no borrow
        flags[FLAG_OVF]   = sub_ovf;
      end
      OP_SLT: result = {31'd0, ($signed(a) < $signed(b))};  // Signed compare
      OP_NOR: result = ~(a | b);
      default: known = 1'b0;  // Zero result, flags stay clear
    endcase
    // Zero flag only for a real operation
    flags[FLAG_ZERO] = known && (result == '0);
  end

endmodule

// File: source/register_file.sv
////////////////////////////////////////
// Register file, 3 read ports, 1 write port
////////////////////////////////////////
`timescale 1ns/1ns

module register_file
  import alu_pkg::*;
#(
  parameter int REG_COUNT = 32  // Implemented registers, 32 max
)
(
  input  logic       clock,
  input  logic       reset,
  input  reg_index_t rd_index_a,     // Pipeline rs
  input  reg_index_t rd_index_b,     // Pipeline rt
  input  reg_index_t rd_index_host,  // APB read
  output word_t      rd_data_a,
  output word_t      rd_data_b,
  output word_t      rd_data_host,
  input  logic       wr_en,
  input  reg_index_t wr_index,
  input  word_t      wr_data
);

  word_t regs [REG_COUNT];  // Storage, entry 0 never written

  // Register 0 and unimplemented indexes read as zero
  function automatic word_t read_reg(input reg_index_t index);
    word_t value;
    value = '0;
    if (index != '0 && int'(index) < REG_COUNT)
      value = regs[index];
    return value;
  endfunction

  ////////////////////////////////////////
  // Combinational reads
  ////////////////////////////////////////
  always_comb
  begin
    rd_data_a    = read_reg(rd_index_a);
    rd_data_b    = read_reg(rd_index_b);
    rd_data_host = read_reg(rd_index_host);
  end

  // Single write port, writes to r0 or out of range dropped
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_index != '0 && int'(wr_index) < REG_COUNT)
      regs[wr_index] <= wr_data;
  end

endmodule

// File: source/write_arbiter.sv
////////////////////////////////////////
// Write port arbiter, pipeline over host
////////////////////////////////////////
`timescale 1ns/1ns

module write_arbiter
  import alu_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       pipe_wr_req,    // Writeback, always served
  input  reg_index_t pipe_wr_index,
  input  word_t      pipe_wr_data,
  input  logic       host_wr_req,    // APB, held until grant
  input  reg_index_t host_wr_index,
  input  word_t      host_wr_data,
  output logic       host_wr_grant,
  output logic       wr_en,
  output reg_index_t wr_index,
  output word_t      wr_data
);

  logic host_waiting;  // Host request lost a cycle to the pipeline

  // Host only gets the port in a cycle the pipeline leaves free
  assign host_wr_grant = host_wr_req && !pipe_wr_req;

  ////////////////////////////////////////
  // Write port mux
  ////////////////////////////////////////
  assign wr_en    = pipe_wr_req || host_wr_grant;
  assign wr_index = pipe_wr_req ? pipe_wr_index : host_wr_index;
  assign wr_data  = pipe_wr_req ? pipe_wr_data : host_wr_data;

  // Pending host request, cleared once granted
  always_ff @(posedge clock)
  begin
    if (reset)
      host_waiting <= 1'b0;
    else
      host_waiting <= host_wr_req && !host_wr_grant;
  end

endmodule

// File: source/apb_host_port.sv
////////////////////////////////////////
// APB slave for host register access
// Reads direct, writes through the arbiter
////////////////////////////////////////
`timescale 1ns/1ns

module apb_host_port
  import alu_pkg::*;
#(
  parameter int REG_COUNT = 32
)
(
  input  logic       clock,
  input  logic       reset,
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [7:0] paddr,          // Register number in bits 6:2
  input  word_t      pwdata,
  output word_t      prdata,
  output logic       pready,
  output logic       pslverr,
  output reg_index_t rd_index_host,
  input  word_t      rd_data_host,
  output logic       host_wr_req,
  output reg_index_t host_wr_index,
  output word_t      host_wr_data,
  input  logic       host_wr_grant
);

  typedef enum logic [1:0] {
    ST_IDLE,    // No transfer
    ST_SETUP,   // Setup decoded, first access cycle
    ST_ACCESS   // Write waiting on the arbiter
  } apb_state_t;

  apb_state_t state;
  reg_index_t index_q;    // Decoded register number
  word_t      wdata_q;    // Write payload
  logic       write_q;    // Transfer is a write
  logic       error_q;    // Write to r0 or unimplemented register
  logic       active;     // Access phase in progress
  logic       bad_index;  // Live decode of paddr
  logic       setup_seen; // Setup phase on the bus while idle

  assign bad_index  = (paddr[6:2] == '0) || (int'(paddr[6:2]) >= REG_COUNT);
  assign setup_seen = (state == ST_IDLE) && psel && !penable;
  assign active     = (state == ST_SETUP) || (state == ST_ACCESS);

  ////////////////////////////////////////
  // Completion
  ////////////////////////////////////////
  // Reads and dropped writes finish at once, good writes on grant
  assign pready  = active && (!write_q || error_q || host_wr_grant);
  assign pslverr = pready && error_q;
  assign prdata  = rd_data_host;

  assign rd_index_host = index_q;
  assign host_wr_req   = active && write_q && !error_q;  // Never for a dropped write
  assign host_wr_index = index_q;
  assign host_wr_data  = wdata_q;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state   <= ST_IDLE;
      write_q <= 1'b0;
      error_q <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (setup_seen)
          begin
            state   <= ST_SETUP;
            write_q <= pwrite;
            error_q <= pwrite && bad_index;  // Reads never error
          end
        ST_SETUP, ST_ACCESS:
          if (pready || !psel)
            state <= ST_IDLE;
          else
            state <= ST_ACCESS;  // Pipeline holds the port
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Address and data captured in setup
  always_ff @(posedge clock)
  begin
    if (setup_seen)
    begin
      index_q <= paddr[6:2];
      wdata_q <= pwdata;
    end
  end

endmodule

// File: source/exec_pipeline.sv
////////////////////////////////////////
// Read, execute, writeback pipeline
// Interlocks on RAW hazards, no forwarding
////////////////////////////////////////
`timescale 1ns/1ns

module exec_pipeline
  import alu_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       issue_valid,
  output logic       issue_ready,
  input  alu_op_t    issue_op,
  input  reg_index_t issue_rs,
  input  reg_index_t issue_rt,
  input  reg_index_t issue_rd,
  output reg_index_t rd_index_a,
  output reg_index_t rd_index_b,
  input  word_t      rd_data_a,
  input  word_t      rd_data_b,
  output word_t      alu_a,
  output word_t      alu_b,
  output alu_op_t    alu_op,
  input  word_t      alu_result,
  input  alu_flags_t alu_flags,
  output logic       pipe_wr_req,
  output reg_index_t pipe_wr_index,
  output word_t      pipe_wr_data,
  output logic       wb_valid,   // Writeback stage valid, doubles as retire
  output reg_index_t wb_rd,
  output word_t      wb_data,
  output alu_flags_t wb_flags
);

  logic       accept;    // Issue handshake
  logic       ex_valid;  // Execute stage
  word_t      ex_a;
  word_t      ex_b;
  alu_op_t    ex_op;
  reg_index_t ex_rd;

  // True when a source of the issuing instruction is still pending
  function automatic logic depends_on(input reg_index_t dest, input reg_index_t rs,
                                      input reg_index_t rt);
    return (dest != '0) && (rs == dest || rt == dest);
  endfunction

  ////////////////////////////////////////
  // Read stage
  ////////////////////////////////////////
  assign rd_index_a = issue_rs;
  assign rd_index_b = issue_rt;
  assign issue_ready = !(ex_valid && depends_on(ex_rd, issue_rs, issue_rt)) &&
                       !(wb_valid && depends_on(wb_rd, issue_rs, issue_rt));
  assign accept = issue_valid && issue_ready;

  // Execute stage drives the ALU
  assign alu_a  = ex_a;
  assign alu_b  = ex_b;
  assign alu_op = ex_op;

  // Writeback, r0 retires without a write
  assign pipe_wr_req   = wb_valid && (wb_rd != '0);
  assign pipe_wr_index = wb_rd;
  assign pipe_wr_data  = wb_data;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      ex_valid <= 1'b0;
      wb_valid <= 1'b0;
    end
    else
    begin
      ex_valid <= accept;
      wb_valid <= ex_valid;
    end
  end

  // Stage payloads
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      ex_a  <= rd_data_a;  // Operands registered at acceptance
      ex_b  <= rd_data_b;
      ex_op <= issue_op;
      ex_rd <= issue_rd;
    end
    if (ex_valid)
    begin
      wb_data  <= alu_result;
      wb_flags <= alu_flags;
      wb_rd    <= ex_rd;
    end
  end

endmodule

// File: source/alu_rf_top.sv
////////////////////////////////////////
// Execution unit top level
////////////////////////////////////////
`timescale 1ns/1ns

module alu_rf_top
  import alu_pkg::*;
#(
  parameter int REG_COUNT = 32
)
(
  input  logic       clock,
  input  logic       reset,
  // APB host port
  input  logic       psel,
  input  logic       penable,
  input  logic       pwrite,
  input  logic [7:0] paddr,
  input  word_t      pwdata,
  output word_t      prdata,
  output logic       pready,
  output logic       pslverr,
  // Issue port
  input  logic       issue_valid,
  output logic       issue_ready,
  input  alu_op_t    issue_op,
  input  reg_index_t issue_rs,
  input  reg_index_t issue_rt,
  input  reg_index_t issue_rd,
  // Retire report
  output logic       wb_valid,
  output reg_index_t wb_rd,
  output word_t      wb_data,
  output alu_flags_t wb_flags
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////
  reg_index_t rd_index_a;
  reg_index_t rd_index_b;
  reg_index_t rd_index_host;
  word_t      rd_data_a;
  word_t      rd_data_b;
  word_t      rd_data_host;
  word_t      alu_a;
  word_t      alu_b;
  alu_op_t    alu_op;
  word_t      alu_result;
  alu_flags_t alu_flags;
  logic       pipe_wr_req;
  reg_index_t pipe_wr_index;
  word_t      pipe_wr_data;
  logic       host_wr_req;
  reg_index_t host_wr_index;
  word_t      host_wr_data;
  logic       host_wr_grant;
  logic       wr_en;
  reg_index_t wr_index;
  word_t      wr_data;

  exec_pipeline i_pipeline (
    .clock         (clock),
    .reset         (reset),
    .issue_valid   (issue_valid),
    .issue_ready   (issue_ready),
    .issue_op      (issue_op),
    .issue_rs      (issue_rs),
    .issue_rt      (issue_rt),
    .issue_rd      (issue_rd),
    .rd_index_a    (rd_index_a),
    .rd_index_b    (rd_index_b),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_op        (alu_op),
    .alu_result    (alu_result),
    .alu_flags     (alu_flags),
    .pipe_wr_req   (pipe_wr_req),
    .pipe_wr_index (pipe_wr_index),
    .pipe_wr_data  (pipe_wr_data),
    .wb_valid      (wb_valid),
    .wb_rd         (wb_rd),
    .wb_data       (wb_data),
    .wb_flags      (wb_flags)
  );

  alu_32 i_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result),
    .flags  (alu_flags)
  );

  register_file #(
    .REG_COUNT (REG_COUNT)
  ) i_regs (
    .clock         (clock),
    .reset         (reset),
    .rd_index_a    (rd_index_a),
    .rd_index_b    (rd_index_b),
    .rd_index_host (rd_index_host),
    .rd_data_a     (rd_data_a),
    .rd_data_b     (rd_data_b),
    .rd_data_host  (rd_data_host),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data)
  );

  // Pipeline writeback wins the write port
  write_arbiter i_arbiter (
    .clock         (clock),
    .reset         (reset),
    .pipe_wr_req   (pipe_wr_req),
    .pipe_wr_index (pipe_wr_index),
    .pipe_wr_data  (pipe_wr_data),
    .host_wr_req   (host_wr_req),
    .host_wr_index (host_wr_index),
    .host_wr_data  (host_wr_data),
    .host_wr_grant (host_wr_grant),
    .wr_en         (wr_en),
    .wr_index      (wr_index),
    .wr_data       (wr_data)
  );

  apb_host_port #(
    .REG_COUNT (REG_COUNT)
  ) i_host (
    .clock         (clock),
    .reset         (reset),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .pslverr       (pslverr),
    .rd_index_host (rd_index_host),
    .rd_data_host  (rd_data_host),
    .host_wr_req   (host_wr_req),
    .host_wr_index (host_wr_index),
    .host_wr_data  (host_wr_data),
    .host_wr_grant (host_wr_grant)
  );

endmodule

// File: tests/alu_rf_props.sv
////////////////////////////////////////
// Bound checks on arbiter and retire timing
////////////////////////////////////////
`timescale 1ns/1ns

module alu_rf_props
  import alu_pkg::*;
(
  input logic clock,
  input logic reset,
  input logic host_wr_req,
  input logic host_waiting,
  input logic accept,
  input logic wb_valid
);

  // Host lost the port to a pipeline write, so its write is still pending
  a_host_waits_for_pipe: assert property (@(posedge clock) disable iff (reset)
    host_waiting |-> host_wr_req)
    else $error("host write finished during a pipeline write");

  // Fixed issue-to-retire distance
  a_retire_two_cycles: assert property (@(posedge clock) disable iff (reset)
    accept |-> ##2 wb_valid)
    else $error("retire did not follow acceptance by 2 cycles");

  a_quiet_after_reset: assert property (@(posedge clock)
    reset |=> !wb_valid)
    else $error("wb_valid high right after reset");

endmodule

////////////////////////////////////////
// Attach points
////////////////////////////////////////
bind write_arbiter alu_rf_props i_arb_props (
  .clock        (clock),
  .reset        (reset),
  .host_wr_req  (host_wr_req),
  .host_waiting (host_waiting),
  .accept       (1'b0),  // Not visible here
  .wb_valid     (1'b0)
);

bind exec_pipeline alu_rf_props i_pipe_props (
  .clock        (clock),
  .reset        (reset),
  .host_wr_req  (1'b0),
  .host_waiting (1'b0),
  .accept       (accept),
  .wb_valid     (wb_valid)
);

// File: tests/alu_rf_tb.sv
////////////////////////////////////////
// Trace-driven testbench for the execution unit
// Reference register model, retire queue, watchdog
////////////////////////////////////////
`timescale 1ns/1ns

module alu_rf_tb
  import alu_pkg::*;
;
  localparam int REG_COUNT = 24;  // Leaves 24..31 unimplemented

  logic       clock;
  logic       reset;
  logic       psel;
  logic       penable;
  logic       pwrite;
  logic [7:0] paddr;
  word_t      pwdata;
  word_t      prdata;
  logic       pready;
  logic       pslverr;
  logic       issue_valid;
  logic       issue_ready;
  alu_op_t    issue_op;
  reg_index_t issue_rs;
  reg_index_t issue_rt;
  reg_index_t issue_rd;
  logic       wb_valid;
  reg_index_t wb_rd;
  word_t      wb_data;
  alu_flags_t wb_flags;

  word_t       model_regs [32];    // Reference register contents
  byte         item_kind [$];      // Trace items
  logic [31:0] item_field [$][6];
  reg_index_t  exp_rd_q [$];       // Outstanding retire expectations
  word_t       exp_data_q [$];
  alu_flags_t  exp_flags_q [$];
  int          exp_cycle_q [$];
  reg_index_t  acc_rd [$];         // Accepted destinations, oldest first
  int          acc_cycle [$];      // Cycle count just before each acceptance
  int          cycle;
  int          watchdog_limit;
  logic [31:0] lfsr_state;

  alu_rf_top #(
    .REG_COUNT (REG_COUNT)
  ) i_dut (
    .clock       (clock),
    .reset       (reset),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue_op    (issue_op),
    .issue_rs    (issue_rs),
    .issue_rt    (issue_rt),
    .issue_rd    (issue_rd),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_flags    (wb_flags)
  );

  always #5 clock = ~clock;  // 10 ns period

  always @(posedge clock)
    cycle <= cycle + 1;

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic compare_word(input string name, input word_t got, input word_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_index(input string name, input reg_index_t got,
                               input reg_index_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_flags(input string name, input alu_flags_t got,
                               input alu_flags_t exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      report_failure($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic word_t model_read(input reg_index_t idx);
    if (idx == 0 || int'(idx) >= REG_COUNT)
      return '0;
    return model_regs[idx];
  endfunction

  function automatic logic writable(input reg_index_t idx);
    return idx != 0 && int'(idx) < REG_COUNT;
  endfunction

  // Hazard rule, sources against destinations in execute or writeback
  function automatic logic model_ready(input reg_index_t rs, input reg_index_t rt);
    logic ready;
    ready = 1'b1;
    foreach (acc_rd[i])
      if ((cycle - acc_cycle[i] == 1 || cycle - acc_cycle[i] == 2) && acc_rd[i] != 0 &&
          (acc_rd[i] == rs || acc_rd[i] == rt))
        ready = 1'b0;
    return ready;
  endfunction

  // Flags as {carry, zero, overflow}
  task automatic ref_alu(input alu_op_t op, input word_t a, input word_t b,
                         output word_t res, output alu_flags_t fl);
    logic [32:0] wide;
    longint      exact;   // Signed result without wrap
    logic        carry;
    logic        ovf;
    logic        known;
    carry = 1'b0;
    ovf   = 1'b0;
    known = 1'b1;
    res   = '0;
    exact = 0;
    case (op)
      OP_AND: res = a & b;
      OP_OR:  res = a | b;
      OP_NOR: res = ~(a | b);
      OP_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      OP_ADD:
      begin
        wide  = {1'b0, a} + {1'b0, b};
        res   = wide[31:0];
        carry = wide[32];
        exact = longint'($signed(a)) + longint'($signed(b));
        ovf   = exact != longint'($signed(res));
      end
      OP_SUB:
      begin
        res   = a - b;
        carry = a >= b;  // No borrow
        exact = longint'($signed(a)) - longint'($signed(b));
        ovf   = exact != longint'($signed(res));
      end
      default: known = 1'b0;
    endcase
    fl = {carry, known && res == '0, ovf};
  endtask

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic int take_bits(input int count);
    logic fb;
    int   value;
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value      = (value << 1) | int'(fb);
    end
    return value;
  endfunction

  task automatic wait_drained();
    while (exp_rd_q.size() != 0)
    begin
      @(negedge clock);
      issue_valid = 1'b0;   // Last instruction already taken
    end
  endtask

  task automatic apb_access(input logic write, input reg_index_t idx, input word_t wdata,
                            output word_t rdata, output logic err);
    @(negedge clock);
    issue_valid = 1'b0;
    psel        = 1'b1;     // Setup phase
    penable     = 1'b0;
    pwrite      = write;
    paddr       = {1'b0, idx, 2'b00};
    pwdata      = wdata;
    @(negedge clock);
    penable = 1'b1;         // Access phase
    #1;
    while (!pready)         // Host waits on the arbiter
    begin
      @(negedge clock);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
  endtask

  task automatic issue_instr(input alu_op_t op, input reg_index_t rs, input reg_index_t rt,
                             input reg_index_t rd, input word_t exp_res,
                             input alu_flags_t exp_fl);
    word_t      res;
    alu_flags_t fl;
    ref_alu(op, model_read(rs), model_read(rt), res, fl);
    if (res !== exp_res || fl !== exp_fl)
      report_failure($sformatf("Trace expects %h/%h but the model gives %h/%h",
                               exp_res, exp_fl, res, fl));
    @(negedge clock);
    psel        = 1'b0;
    penable     = 1'b0;
    issue_valid = 1'b1;
    issue_op    = op;
    issue_rs    = rs;
    issue_rt    = rt;
    issue_rd    = rd;
    #1;
    compare_bit("issue_ready", issue_ready, model_ready(rs, rt));
    while (!issue_ready)    // Hazard stall, fields held
    begin
      @(negedge clock);
      #1;
      compare_bit("issue_ready", issue_ready, model_ready(rs, rt));
    end
    acc_rd.push_back(rd);
    acc_cycle.push_back(cycle);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    exp_flags_q.push_back(fl);
    exp_cycle_q.push_back(cycle + 2);  // Cycle after the one following acceptance
    if (writable(rd))
      model_regs[rd] = res;
    @(posedge clock);
  endtask

  ////////////////////////////////////////
  // Retire monitor
  ////////////////////////////////////////
  always @(negedge clock)
  begin
    if (!reset && wb_valid)
    begin
      if (exp_rd_q.size() == 0)
        report_failure("Retire report seen with no instruction outstanding");
      else
      begin
        compare_index("wb_rd", wb_rd, exp_rd_q.pop_front());
        compare_word("wb_data", wb_data, exp_data_q.pop_front());
        compare_flags("wb_flags", wb_flags, exp_flags_q.pop_front());
        if (cycle != exp_cycle_q.pop_front())
          report_failure("Instruction did not retire 2 cycles after acceptance");
      end
    end
  end

  // Watchdog, armed once the trace length is known
  initial
  begin
    wait (watchdog_limit != 0);
    repeat (watchdog_limit) @(posedge clock);
    $display("Timeout: the trace did not finish in %0d cycles", watchdog_limit);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial
  begin
    int          fd;
    int          count;
    int          gap;
    string       line;
    byte         kind;
    logic [31:0] f [6];
    word_t       rdata;
    logic        err;
    clock          = 1'b0;
    reset          = 1'b1;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    issue_valid    = 1'b0;
    issue_op       = '0;
    issue_rs       = '0;
    issue_rt       = '0;
    issue_rd       = '0;
    cycle          = 0;
    watchdog_limit = 0;
    lfsr_state     = 32'h057e6e72;
    for (int i = 0; i < 32; i++)
      model_regs[i] = '0;

    fd = $fopen("tests/alu_rf_trace.txt", "r");
    if (fd == 0)
      report_failure("Could not open the trace file");
    while (!$feof(fd))
    begin
      line = "";
      count = $fgets(line, fd);
      f = '{default: '0};
      kind = " ";
      count = $sscanf(line, "%c %h %h %h %h %h %h", kind, f[0], f[1], f[2], f[3], f[4], f[5]);
      if (kind == "W" || kind == "R" || kind == "I" || kind == "P")
      begin
        item_kind.push_back(kind);
        item_field.push_back(f);
      end
    end
    $fclose(fd);
    if (item_kind.size() == 0)
      report_failure("Trace file holds no items");
    watchdog_limit = item_kind.size() * 40 + 100;

    repeat (10) @(negedge clock);
    // Quiet outputs out of reset
    compare_bit("issue_ready", issue_ready, 1'b1);
    compare_bit("pready", pready, 1'b0);
    compare_bit("pslverr", pslverr, 1'b0);
    compare_bit("wb_valid", wb_valid, 1'b0);
    reset = 1'b0;

    foreach (item_kind[i])
    begin
      f    = item_field[i];
      kind = item_kind[i];
      gap  = 0;
      if (kind != "P")    // P items go back to back
        gap = take_bits(2);
      if (gap > 0)
      begin
        @(negedge clock);
        issue_valid = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        repeat (gap - 1) @(negedge clock);
      end
      case (kind)
        "W":
        begin
          if (f[2][0] !== !writable(f[0][4:0]))
            report_failure("Trace error bit disagrees with the register map");
          apb_access(1'b1, f[0][4:0], f[1], rdata, err);
          compare_bit("pslverr", err, f[2][0]);
          if (writable(f[0][4:0]))
            model_regs[f[0][4:0]] = f[1];
        end
        "R":
        begin
          if (f[1] !== model_read(f[0][4:0]))
            report_failure("Trace read data disagrees with the model");
          wait_drained();  // Let pending writebacks land
          apb_access(1'b0, f[0][4:0], '0, rdata, err);
          compare_bit("pslverr", err, f[2][0]);
          compare_word("prdata", rdata, model_read(f[0][4:0]));
        end
        default:
          issue_instr(f[0][3:0], f[1][4:0], f[2][4:0], f[3][4:0], f[4], f[5][2:0]);
      endcase
    end

    @(negedge clock);
    issue_valid = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    wait_drained();
    repeat (3) @(negedge clock);
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: tests/alu_rf_trace.txt
# W idx data err | R idx data err | I/P op rs rt rd result flags (hex)
# P issues with no idle gap; flags are {carry, zero, overflow}
W 01 0000000f 0
W 02 00000003 0
W 03 7fffffff 0
W 04 80000000 0
W 05 ffffffff 0
W 00 12345678 1
W 1a deadbeef 1
R 01 0000000f 0
R 00 00000000 0
R 1a 00000000 0
R 05 ffffffff 0
I 0 01 02 06 00000003 0
I 1 01 02 07 0000000f 0
I 2 03 03 08 fffffffe 1
I 6 04 01 09 7ffffff1 5
I 7 04 01 0a 00000001 0
I c 01 02 0b fffffff0 0
I 3 01 02 0c 00000000 0
I 6 01 01 0d 00000000 6
I 2 05 02 0e 00000002 4
I 6 02 01 0f fffffff4 0
W 10 00000003 0
W 11 00000001 0
P 6 10 11 10 00000002 4
P 2 12 10 12 00000002 0
P 6 10 11 10 00000001 4
P 2 12 10 12 00000003 0
P 6 10 11 10 00000000 6
P 2 12 10 12 00000003 0
R 10 00000000 0
R 12 00000003 0
R 11 00000001 0
P 2 01 02 13 00000012 0
W 13 0000aaaa 0
P 0 05 01 14 0000000f 0
W 15 00000055 0
R 13 0000aaaa 0
R 14 0000000f 0
R 15 00000055 0
P 1 01 02 16 0000000f 0
P 0 01 02 17 00000003 0
P 2 01 02 15 00000012 0
P c 00 00 00 ffffffff 0
R 16 0000000f 0
R 17 00000003 0
R 15 00000012 0
R 00 00000000 0

// File: flist.f
source/alu_pkg.sv
source/alu_32.sv
source/register_file.sv
source/write_arbiter.sv
source/apb_host_port.sv
source/exec_pipeline.sv
source/alu_rf_top.sv
tests/alu_rf_props.sv
tests/alu_rf_tb.sv

// File: Makefile
TOP = alu_rf_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	verilator --lint-only --timing -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
